/* source/fpmul_pkg.sv */
/*
  binary32 multiplier shared definitions
  - format constants and canonical quiet NaN
  - fp32 word union, rounding modes
  - operand class, exception flags, stage-1 record
*/
package fpmul_pkg;

  localparam logic [7:0]  exp_bias  = 8'd127;
  localparam logic [7:0]  exp_max   = 8'd254;
  localparam logic [31:0] qnan_word = 32'h7fc0_0000;

  // special result select codes
  localparam logic [1:0] sel_zero = 2'd0;
  localparam logic [1:0] sel_inf  = 2'd1;
  localparam logic [1:0] sel_nan  = 2'd2;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp32_fields_t;

  // one word, raw or field view
  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t f;
  } fp32_t;

  typedef enum logic [1:0] {
    rne = 2'd0,
    rtz = 2'd1,
    rup = 2'd2,
    rdn = 2'd3
  } rmode_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  typedef struct packed {
    logic zero;
    logic inf;
    logic nan;
    logic snan;
  } fp_class_t;

  // record handed from decode to round/pack
  typedef struct packed {
    logic              valid;
    logic              sign;
    logic signed [9:0] exp_sum;
    rmode_t            rmode;
    logic              special;
    logic [1:0]        special_word_sel;
    logic              invalid;
  } mul_stage_t;

endpackage

/* source/fp_operand_decode.sv */
/*
  fp multiplier stage 1 decode
  - operand classification, subnormals read as zero
  - special case selection and invalid detection
  - product sign and unbiased exponent sum
*/
`timescale 1ns/1ns

module fp_operand_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en,
  input  fpmul_pkg::fp32_t       a,
  input  fpmul_pkg::fp32_t       b,
  input  fpmul_pkg::rmode_t      rmode,
  output fpmul_pkg::mul_stage_t  stage1
);
  import fpmul_pkg::*;

  fp_class_t         a_cls;
  fp_class_t         b_cls;
  logic              inf_times_zero;
  logic              res_nan;
  logic              res_inf;
  logic              res_zero;
  logic              res_invalid;
  logic [1:0]        word_sel;
  logic signed [9:0] exp_sum;

  function automatic fp_class_t classify(input fp32_t op);
    fp_class_t c;
    logic      exp_ones;
    exp_ones = &op.f.exp;
    // exponent zero covers subnormals too
    c.zero = (op.f.exp == 8'h00);
    c.inf  = exp_ones && (op.f.frac == 23'h0);
    c.nan  = exp_ones && (op.f.frac != 23'h0);
    c.snan = c.nan && !op.f.frac[22];
    return c;
  endfunction

  assign a_cls = classify(a);
  assign b_cls = classify(b);

  assign inf_times_zero = (a_cls.inf && b_cls.zero) || (b_cls.inf && a_cls.zero);
  assign res_nan        = a_cls.nan || b_cls.nan || inf_times_zero;
  assign res_inf        = !res_nan && (a_cls.inf || b_cls.inf);
  assign res_zero       = !res_nan && !res_inf && (a_cls.zero || b_cls.zero);
  assign res_invalid    = inf_times_zero || a_cls.snan || b_cls.snan;

  assign word_sel = res_nan ? sel_nan : (res_inf ? sel_inf : sel_zero);

  // biased + biased - bias, may go negative
  assign exp_sum = $signed({2'b00, a.f.exp}) + $signed({2'b00, b.f.exp})
                 - $signed({2'b00, exp_bias});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1.valid <= 1'b0;
    end else begin
      stage1.valid <= en;
    end
    stage1.sign             <= a.f.sign ^ b.f.sign;
    stage1.exp_sum          <= exp_sum;
    stage1.rmode            <= rmode;
    stage1.special          <= res_nan || res_inf || res_zero;
    stage1.special_word_sel <= word_sel;
    stage1.invalid          <= res_invalid;
  end

  a_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
    stage1.valid |-> (stage1.special_word_sel != 2'd3));

endmodule

/* source/mant_multiplier.sv */
/*
  registered 24x24 significand multiply
  - full 48-bit product, one cycle
*/
`timescale 1ns/1ns

module mant_multiplier (
  input  logic        clk,
  input  logic [23:0] a_sig,
  input  logic [23:0] b_sig,
  output logic [47:0] product
);

  logic [47:0] product_d;

  // single multiply stands in for the compressor tree and final adder
  assign product_d = a_sig * b_sig;

  always_ff @(posedge clk) begin
    product <= product_d;
  end

  // normalized inputs land in [1,4)
  a_prod_norm: assert property (@(posedge clk)
    (a_sig[23] && b_sig[23]) |=> (product[47] || product[46]));

endmodule

/* source/fp_round_pack.sv */
/*
  fp multiplier stage 2
  - normalize by one place, round in four modes
  - overflow and flush-to-zero range check
  - special result bypass, exception flags, output register
*/
`timescale 1ns/1ns

module fp_round_pack (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fpmul_pkg::mul_stage_t  stage1,
  input  logic [47:0]            product,
  output logic                   out_valid,
  output fpmul_pkg::fp32_t       result,
  output fpmul_pkg::fp_flags_t   flags
);
  import fpmul_pkg::*;

  logic [23:0]       sig;
  logic              round_bit;
  logic              sticky;
  logic              lost;
  logic              inc;
  logic [24:0]       sig_rnd;
  logic signed [9:0] exp_norm;
  logic signed [9:0] exp_fin;
  logic [22:0]       frac_fin;
  logic              ovf;
  logic              unf;
  logic              to_max;
  fp32_t             word_d;
  fp_flags_t         flags_d;

  // upper or lower window of a product in [1,4)
  always_comb begin
    if (product[47]) begin
      sig       = product[47:24];
      round_bit = product[23];
      sticky    = |product[22:0];
      exp_norm  = stage1.exp_sum + 10'sd1;
    end else begin
      sig       = product[46:23];
      round_bit = product[22];
      sticky    = |product[21:0];
      exp_norm  = stage1.exp_sum;
    end
  end

  assign lost = round_bit || sticky;

  always_comb begin
    case (stage1.rmode)
      rne:     inc = round_bit && (sticky || sig[0]);
      rtz:     inc = 1'b0;
      rup:     inc = lost && !stage1.sign;
      rdn:     inc = lost && stage1.sign;
      default: inc = 1'b0;
    endcase
  end

  assign sig_rnd = {1'b0, sig} + {24'h0, inc};

  // a carry out leaves a zero fraction and only bumps the exponent
  assign exp_fin  = exp_norm + $signed({9'b0, sig_rnd[24]});
  assign frac_fin = sig_rnd[22:0];

  assign ovf = exp_fin > $signed({2'b00, exp_max});
  assign unf = exp_fin < 10'sd1;

  // modes that never round away from zero for this sign
  assign to_max = (stage1.rmode == rtz)
               || (stage1.rmode == rup && stage1.sign)
               || (stage1.rmode == rdn && !stage1.sign);

  always_comb begin
    word_d  = '0;
    flags_d = '0;
    if (stage1.special) begin
      flags_d.invalid = stage1.invalid;
      case (stage1.special_word_sel)
        sel_nan: word_d.bits = qnan_word;
        sel_inf: word_d.f    = '{sign: stage1.sign, exp: 8'hff, frac: 23'h0};
        default: word_d.f    = '{sign: stage1.sign, exp: 8'h00, frac: 23'h0};
      endcase
    end else if (ovf) begin
      flags_d.overflow = 1'b1;
      flags_d.inexact  = 1'b1;
      if (to_max) begin
        word_d.f = '{sign: stage1.sign, exp: exp_max, frac: 23'h7fffff};
      end else begin
        word_d.f = '{sign: stage1.sign, exp: 8'hff, frac: 23'h0};
      end
    end else if (unf) begin
      // flush to signed zero
      flags_d.underflow = 1'b1;
      flags_d.inexact   = 1'b1;
      word_d.f = '{sign: stage1.sign, exp: 8'h00, frac: 23'h0};
    end else begin
      flags_d.inexact = lost;
      word_d.f = '{sign: stage1.sign, exp: exp_fin[7:0], frac: frac_fin};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= stage1.valid;
    end
    result <= word_d;
    flags  <= flags_d;
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid));

endmodule

/* source/fpmul_top.sv */
/*
  pipelined binary32 multiplier, two cycle latency
  - decode and significand multiply in stage 1
  - round and pack in stage 2
*/
`timescale 1ns/1ns

module fpmul_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  fpmul_pkg::fp32_t      a,
  input  fpmul_pkg::fp32_t      b,
  input  fpmul_pkg::rmode_t     rmode,
  output logic                  out_valid,
  output fpmul_pkg::fp32_t      result,
  output fpmul_pkg::fp_flags_t  flags
);
  import fpmul_pkg::*;

  mul_stage_t  stage1;
  logic [47:0] product;

  fp_operand_decode u_decode (
    .clk    (clk),
    .rst_n  (rst_n),
    .en     (en),
    .a      (a),
    .b      (b),
    .rmode  (rmode),
    .stage1 (stage1)
  );

  // hidden bit set for any nonzero exponent
  mant_multiplier u_mult (
    .clk     (clk),
    .a_sig   ({|a.f.exp, a.f.frac}),
    .b_sig   ({|b.f.exp, b.f.frac}),
    .product (product)
  );

  fp_round_pack u_round (
    .clk       (clk),
    .rst_n     (rst_n),
    .stage1    (stage1),
    .product   (product),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

endmodule

/* tests/fpmul_model.svh */
/*
  reference model for the binary32 multiplier
  - operand kinds, expected product and flags
  - xorshift generator and biased operand picker
*/
`ifndef fpmul_model_svh
`define fpmul_model_svh

localparam int k_norm = 0;
localparam int k_zero = 1;
localparam int k_inf  = 2;
localparam int k_nan  = 3;

// subnormals count as zero
function automatic int op_kind(input fp32_t op);
  if (op.f.exp == 8'h00) begin
    return k_zero;
  end
  if (op.f.exp != 8'hff) begin
    return k_norm;
  end
  return (op.f.frac == 23'h0) ? k_inf : k_nan;
endfunction

function automatic void model_mul(input fp32_t a, input fp32_t b, input rmode_t rm,
                                  output fp32_t res, output fp_flags_t fl);
  int              ka;
  int              kb;
  int              e;
  int              shift;
  logic            sign;
  logic            bad;
  logic            inc;
  longint unsigned prod;
  longint unsigned sig;
  longint unsigned rem;
  longint unsigned half;
  ka = op_kind(a);
  kb = op_kind(b);
  sign = a.f.sign ^ b.f.sign;
  bad = (ka == k_inf && kb == k_zero) || (ka == k_zero && kb == k_inf);
  fl = '0;
  res.bits = 32'h0;
  if (ka == k_nan || kb == k_nan || bad) begin
    res.bits = qnan_word;
    // signaling NaN has the top fraction bit clear
    fl.invalid = bad || (ka == k_nan && !a.f.frac[22]) || (kb == k_nan && !b.f.frac[22]);
  end else if (ka == k_inf || kb == k_inf) begin
    res.bits = {sign, 8'hff, 23'h0};
  end else if (ka == k_zero || kb == k_zero) begin
    res.bits = {sign, 31'h0};
  end else begin
    prod = (64'h80_0000 | 64'(a.f.frac)) * (64'h80_0000 | 64'(b.f.frac));
    e = int'(a.f.exp) + int'(b.f.exp) - int'(exp_bias);
    shift = (prod >= 64'h8000_0000_0000) ? 24 : 23;
    e = e + shift - 23;
    sig = prod >> shift;
    rem = prod & ((64'd1 << shift) - 64'd1);
    half = 64'd1 << (shift - 1);
    case (rm)
      rne: inc = (rem > half) || (rem == half && sig[0]);
      rup: inc = (rem != 0) && !sign;
      rdn: inc = (rem != 0) && sign;
      default: inc = 1'b0;
    endcase
    if (inc) begin
      sig = sig + 64'd1;
    end
    if (sig == 64'h100_0000) begin
      sig = sig >> 1;
      e = e + 1;
    end
    if (e > int'(exp_max)) begin
      fl.overflow = 1'b1;
      fl.inexact = 1'b1;
      if (rm == rtz || (rm == rup && sign) || (rm == rdn && !sign)) begin
        res.bits = {sign, 8'hfe, 23'h7fffff};
      end else begin
        res.bits = {sign, 8'hff, 23'h0};
      end
    end else if (e < 1) begin
      fl.underflow = 1'b1;
      fl.inexact = 1'b1;
      res.bits = {sign, 31'h0};
    end else begin
      fl.inexact = (rem != 0);
      res.bits = {sign, e[7:0], sig[22:0]};
    end
  end
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// mostly random words, with exponents pushed toward the edges
task automatic pick_operand(inout logic [31:0] state, output fp32_t op);
  state = xorshift32(state);
  op.bits = state;
  state = xorshift32(state);
  case (state[2:0])
    3'd0: begin
      op.f.exp = 8'h00;
      if (state[3]) begin
        op.f.frac = 23'h0;
      end
    end
    3'd1: begin
      op.f.exp = 8'hff;
      if (state[4]) begin
        op.f.frac = 23'h0;
      end
    end
    3'd2: op.f.exp = 8'd200 + 8'(state[15:8] % 8'd55);
    3'd3: op.f.exp = 8'd1 + 8'(state[15:8] % 8'd60);
    3'd4, 3'd5: op.f.exp = 8'd97 + 8'(state[15:8] % 8'd60);
    default: ;
  endcase
endtask

`endif

/* tests/tb_fpmul.sv */
/*
  testbench for the binary32 multiplier
  - clock, reset, random operands and rounding modes
  - expected-value queue checked at the output, watchdog
*/
`timescale 1ns/1ns

module tb_fpmul;
  import fpmul_pkg::*;

  `include "fpmul_model.svh"

  localparam int num_ops = 2000;

  typedef struct packed {
    int        due;
    fp32_t     word;
    fp_flags_t flags;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        en;
  fp32_t       a;
  fp32_t       b;
  rmode_t      rmode;
  logic        out_valid;
  fp32_t       result;
  fp_flags_t   flags;
  expect_t     exp_q[$];
  logic [31:0] rng;
  int          cyc;
  int          result_errs;
  int          flag_errs;
  int          protocol_errs;

  fpmul_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .a         (a),
    .b         (b),
    .rmode     (rmode),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_result(input fp32_t got, input fp32_t want);
    if (got.bits !== want.bits) begin
      result_errs++;
      $display("error at %0t: result got %08h expected %08h", $time, got.bits, want.bits);
    end
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t want);
    if (got !== want) begin
      flag_errs++;
      $display("error at %0t: flags got %04b expected %04b", $time, got, want);
    end
  endtask

  // one call per falling edge, outputs are stable here
  task automatic check_outputs();
    expect_t e;
    cyc++;
    if ($isunknown(out_valid)) begin
      protocol_errs++;
      $display("out_valid is unknown at %0t", $time);
    end else if (out_valid) begin
      if (exp_q.size() == 0) begin
        protocol_errs++;
        $display("out_valid high at %0t with no operation in flight", $time);
      end else begin
        e = exp_q.pop_front();
        if (e.due != cyc) begin
          protocol_errs++;
          $display("result at %0t came out in cycle %0d instead of %0d", $time, cyc, e.due);
        end
        check_result(result, e.word);
        check_flags(flags, e.flags);
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
      protocol_errs++;
      $display("out_valid missing at %0t for an operation due in cycle %0d", $time, exp_q[0].due);
      e = exp_q.pop_front();
    end
  endtask

  task automatic drive_inputs();
    expect_t   e;
    fp32_t     res;
    fp_flags_t fl;
    rng = xorshift32(rng);
    en = (rng[1:0] != 2'b00);
    rmode = rmode_t'(rng[3:2]);
    pick_operand(rng, a);
    pick_operand(rng, b);
    if (en) begin
      model_mul(a, b, rmode, res, fl);
      // accepted at the next rising edge, visible two falling edges on
      e.due = cyc + 2;
      e.word = res;
      e.flags = fl;
      exp_q.push_back(e);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    en = 1'b0;
    a.bits = 32'h0;
    b.bits = 32'h0;
    rmode = rne;
    rng = 32'h1333;
    cyc = 0;
    result_errs = 0;
    flag_errs = 0;
    protocol_errs = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (num_ops) begin
      @(negedge clk);
      check_outputs();
      drive_inputs();
    end
    // drain the pipeline
    repeat (4) begin
      @(negedge clk);
      check_outputs();
      en = 1'b0;
    end
    if (exp_q.size() != 0) begin
      protocol_errs++;
      $display("%0d operations never produced out_valid", exp_q.size());
    end
    $display("errors: result %0d, flags %0d, protocol %0d", result_errs, flag_errs,
             protocol_errs);
    if (result_errs + flag_errs + protocol_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #((num_ops + 20) * 100);
    $display("timeout: run did not finish within %0d ns", (num_ops + 20) * 100);
    $display("Verification failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+tests
source/fpmul_pkg.sv
source/fp_operand_decode.sv
source/mant_multiplier.sv
source/fp_round_pack.sv
source/fpmul_top.sv
tests/tb_fpmul.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fpmul -f src.f \
  --Mdir obj_dir -o tb_fpmul_sim

out=$(./obj_dir/tb_fpmul_sim)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
else
  exit 1
fi
